// ==== design/dcache.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               dmem_ren,
  input  logic               dmem_wen,
  input  dcache_pkg::word_t  dmem_addr,
  input  dcache_pkg::word_t  dmem_store,
  output logic               dhit,
  output dcache_pkg::word_t  dmem_load,
  input  logic               dwait,
  input  dcache_pkg::word_t  dload,
  output logic               dren,
  output logic               dwen,
  output dcache_pkg::word_t  daddr,
  output dcache_pkg::word_t  dstore,
  input  logic               cc_grant,
  output logic               cc_inv_req,
  output dcache_pkg::word_t  cc_addr,
  input  logic               snoop_req,
  input  logic               snoop_excl,
  input  dcache_pkg::word_t  snoop_addr,
  output logic               snoop_ack
);

  import dcache_pkg::*;

  logic [`DCACHE_IDX_W-1:0] idx, snoop_idx;
  logic [`DCACHE_TAG_W-1:0] tag, snoop_tag;
  logic wword;
  word_t wdat;
  logic way0_wen, way1_wen;
  logic way0_set_valid, way1_set_valid;
  logic way0_clear_valid, way1_clear_valid;
  logic way0_set_dirty, way1_set_dirty;
  logic way0_clear_dirty, way1_clear_dirty;
  logic way0_write_tag, way1_write_tag;
  logic way0_hit, way1_hit;
  logic way0_snoop_hit, way1_snoop_hit;
  dcache_frame_t way0_frame, way1_frame;
  dcache_frame_t way0_snoop_frame, way1_snoop_frame;

  // every controller port has a same-named port or wire here.
  dcache_ctrl u_ctrl (.*);

  dcache_frame_array u_way0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .idx         (idx),
    .snoop_idx   (snoop_idx),
    .tag         (tag),
    .snoop_tag   (snoop_tag),
    .wen         (way0_wen),
    .wword       (wword),
    .wdat        (wdat),
    .set_valid   (way0_set_valid),
    .clear_valid (way0_clear_valid),
    .set_dirty   (way0_set_dirty),
    .clear_dirty (way0_clear_dirty),
    .write_tag   (way0_write_tag),
    .hit         (way0_hit),
    .snoop_hit   (way0_snoop_hit),
    .frame       (way0_frame),
    .snoop_frame (way0_snoop_frame)
  );

  dcache_frame_array u_way1 (
    .CLK         (CLK),
    .nRST        (nRST),
    .idx         (idx),
    .snoop_idx   (snoop_idx),
    .tag         (tag),
    .snoop_tag   (snoop_tag),
    .wen         (way1_wen),
    .wword       (wword),
    .wdat        (wdat),
    .set_valid   (way1_set_valid),
    .clear_valid (way1_clear_valid),
    .set_dirty   (way1_set_dirty),
    .clear_dirty (way1_clear_dirty),
    .write_tag   (way1_write_tag),
    .hit         (way1_hit),
    .snoop_hit   (way1_snoop_hit),
    .frame       (way1_frame),
    .snoop_frame (way1_snoop_frame)
  );

endmodule

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       dmem_ren, dmem_wen,
  input  dcache_pkg::word_t          dmem_addr, dmem_store,
  output logic                       dhit,
  output dcache_pkg::word_t          dmem_load,
  input  logic                       dwait,
  input  dcache_pkg::word_t          dload,
  output logic                       dren, dwen,
  output dcache_pkg::word_t          daddr, dstore,
  input  logic                       cc_grant,
  output logic                       cc_inv_req,
  output dcache_pkg::word_t          cc_addr,
  input  logic                       snoop_req, snoop_excl,
  input  dcache_pkg::word_t          snoop_addr,
  output logic                       snoop_ack,
  output logic [`DCACHE_IDX_W-1:0]   idx, snoop_idx,
  output logic [`DCACHE_TAG_W-1:0]   tag, snoop_tag,
  output logic                       wword,
  output dcache_pkg::word_t          wdat,
  output logic                       way0_wen, way1_wen,
  output logic                       way0_set_valid, way1_set_valid,
  output logic                       way0_clear_valid, way1_clear_valid,
  output logic                       way0_set_dirty, way1_set_dirty,
  output logic                       way0_clear_dirty, way1_clear_dirty,
  output logic                       way0_write_tag, way1_write_tag,
  input  logic                       way0_hit, way1_hit,
  input  logic                       way0_snoop_hit, way1_snoop_hit,
  input  dcache_pkg::dcache_frame_t  way0_frame, way1_frame,
  input  dcache_pkg::dcache_frame_t  way0_snoop_frame, way1_snoop_frame
);

  import dcache_pkg::*;

  localparam int N_SETS = 2**`DCACHE_IDX_W;

  dcache_state_t state, nxt_state;
  logic [N_SETS-1:0] lru;
  logic lru_upd;
  logic victim_q, pick;
  logic hit_way, dem_any;
  logic snoop_way, snoop_any;
  logic [`DCACHE_IDX_W-1:0] dm_idx;
  logic dm_word;
  dcache_frame_t hit_fr, pick_fr, vic_fr, snoop_fr;
  dcache_state_t miss_state;
  logic [1:0] wen_v, set_valid_v, clear_valid_v;
  logic [1:0] set_dirty_v, clear_dirty_v, write_tag_v;

  assign dm_idx    = dmem_addr[`DCACHE_IDX_W+2:3];
  assign dm_word   = dmem_addr[2];
  assign tag       = dmem_addr[`DCACHE_WORD_W-1:`DCACHE_IDX_W+3];
  assign snoop_idx = snoop_addr[`DCACHE_IDX_W+2:3];
  assign snoop_tag = snoop_addr[`DCACHE_WORD_W-1:`DCACHE_IDX_W+3];

  // while a snoop is served the flag writes must land on the snooped set.
  assign idx = (state inside {SNOOP_WB1, SNOOP_WB2, SNOOP_TRANS}) ? snoop_idx : dm_idx;

  assign dem_any   = way0_hit | way1_hit;
  assign hit_way   = way1_hit;
  assign hit_fr    = hit_way ? way1_frame : way0_frame;
  assign snoop_any = way0_snoop_hit | way1_snoop_hit;
  assign snoop_way = way1_snoop_hit;
  assign snoop_fr  = snoop_way ? way1_snoop_frame : way0_snoop_frame;

  // an invalid way is always the cheaper victim.
  always_comb
  begin
    if (!way0_frame.valid)
      pick = 1'b0;
    else if (!way1_frame.valid)
      pick = 1'b1;
    else
      pick = lru[dm_idx];
  end

  assign pick_fr    = pick ? way1_frame : way0_frame;
  assign vic_fr     = victim_q ? way1_frame : way0_frame;
  assign miss_state = pick_fr.dirty ? EVICT_WB1 : FILL1;

  assign dmem_load = hit_fr.data[dm_word];
  assign cc_addr   = {dmem_addr[`DCACHE_WORD_W-1:3], 3'b000};

  assign way0_wen         = wen_v[0];
  assign way1_wen         = wen_v[1];
  assign way0_set_valid   = set_valid_v[0];
  assign way1_set_valid   = set_valid_v[1];
  assign way0_clear_valid = clear_valid_v[0];
  assign way1_clear_valid = clear_valid_v[1];
  assign way0_set_dirty   = set_dirty_v[0];
  assign way1_set_dirty   = set_dirty_v[1];
  assign way0_clear_dirty = clear_dirty_v[0];
  assign way1_clear_dirty = clear_dirty_v[1];
  assign way0_write_tag   = write_tag_v[0];
  assign way1_write_tag   = write_tag_v[1];

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state    <= IDLE;
      lru      <= '0;
      victim_q <= 1'b0;
    end
    else
    begin
      state <= nxt_state;
      // lru points at the way to evict next, so a hit points it away.
      if (lru_upd)
        lru[dm_idx] <= ~hit_way;
      if (state == IDLE || state == INV_REQ)
        victim_q <= pick;
    end
  end

  always_comb
  begin
    nxt_state     = state;
    dhit          = 1'b0;
    dren          = 1'b0;
    dwen          = 1'b0;
    daddr         = '0;
    dstore        = '0;
    cc_inv_req    = 1'b0;
    snoop_ack     = 1'b0;
    lru_upd       = 1'b0;
    wword         = 1'b0;
    wdat          = '0;
    wen_v         = '0;
    set_valid_v   = '0;
    clear_valid_v = '0;
    set_dirty_v   = '0;
    clear_dirty_v = '0;
    write_tag_v   = '0;

    case (state)
      IDLE:
      begin
        if (snoop_req)
        begin
          if (snoop_any && snoop_fr.dirty)
            nxt_state = SNOOP_WB1;
          else
            nxt_state = SNOOP_TRANS;
        end
        else if (dmem_ren)
        begin
          if (dem_any)
          begin
            dhit    = 1'b1;
            lru_upd = 1'b1;
          end
          else
            nxt_state = miss_state;
        end
        else if (dmem_wen)
        begin
          // only a modified line may be written without asking the bus.
          if (dem_any && hit_fr.dirty)
          begin
            dhit           = 1'b1;
            lru_upd        = 1'b1;
            wen_v[hit_way] = 1'b1;
            wword          = dm_word;
            wdat           = dmem_store;
          end
          else
            nxt_state = INV_REQ;
        end
      end
      INV_REQ:
      begin
        cc_inv_req = 1'b1;
        if (cc_grant)
          nxt_state = dem_any ? FILL_DONE : miss_state;
      end
      EVICT_WB1, EVICT_WB2:
      begin
        dwen   = 1'b1;
        daddr  = {vic_fr.tag, dm_idx, (state == EVICT_WB2), 2'b00};
        dstore = vic_fr.data[state == EVICT_WB2];
        if (!dwait)
          nxt_state = (state == EVICT_WB1) ? EVICT_WB2 : FILL1;
      end
      FILL1:
      begin
        dren  = 1'b1;
        daddr = {tag, dm_idx, 1'b0, 2'b00};
        if (!dwait)
        begin
          // the frame stays invalid until the second word has arrived.
          wen_v[victim_q]         = 1'b1;
          wdat                    = dload;
          write_tag_v[victim_q]   = 1'b1;
          clear_valid_v[victim_q] = 1'b1;
          clear_dirty_v[victim_q] = 1'b1;
          nxt_state               = FILL2;
        end
      end
      FILL2:
      begin
        dren  = 1'b1;
        daddr = {tag, dm_idx, 1'b1, 2'b00};
        if (!dwait)
        begin
          wen_v[victim_q]       = 1'b1;
          wword                 = 1'b1;
          wdat                  = dload;
          set_valid_v[victim_q] = 1'b1;
          nxt_state             = FILL_DONE;
        end
      end
      FILL_DONE:
      begin
        dhit    = 1'b1;
        lru_upd = 1'b1;
        if (dmem_wen)
        begin
          wen_v[hit_way]       = 1'b1;
          wword                = dm_word;
          wdat                 = dmem_store;
          set_dirty_v[hit_way] = 1'b1;
        end
        nxt_state = IDLE;
      end
      SNOOP_WB1, SNOOP_WB2:
      begin
        dwen   = 1'b1;
        daddr  = {snoop_addr[`DCACHE_WORD_W-1:3], (state == SNOOP_WB2), 2'b00};
        dstore = snoop_fr.data[state == SNOOP_WB2];
        if (!dwait)
          nxt_state = (state == SNOOP_WB1) ? SNOOP_WB2 : SNOOP_TRANS;
      end
      SNOOP_TRANS:
      begin
        snoop_ack = 1'b1;
        if (snoop_any)
        begin
          clear_dirty_v[snoop_way] = 1'b1;
          if (snoop_excl)
            clear_valid_v[snoop_way] = 1'b1;
        end
        nxt_state = IDLE;
      end
      default:
        nxt_state = IDLE;
    endcase
  end

  // a stalled memory access keeps its request, address and data until dwait drops.
  mem_req_stable: assert property (
    @(posedge CLK) disable iff (!nRST)
    (dren || dwen) && dwait |=> $stable(dren) && $stable(dwen) && $stable(daddr)
      && $stable(dstore)
  );

  // dhit is only given while the requested line is present in one of the ways.
  dhit_on_hit: assert property (
    @(posedge CLK) disable iff (!nRST)
    dhit |-> (way0_hit || way1_hit)
  );

endmodule

// ==== design/dcache_frame_array.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_frame_array (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic [`DCACHE_IDX_W-1:0]   idx,
  input  logic [`DCACHE_IDX_W-1:0]   snoop_idx,
  input  logic [`DCACHE_TAG_W-1:0]   tag,
  input  logic [`DCACHE_TAG_W-1:0]   snoop_tag,
  input  logic                       wen,
  input  logic                       wword,
  input  dcache_pkg::word_t          wdat,
  input  logic                       set_valid,
  input  logic                       clear_valid,
  input  logic                       set_dirty,
  input  logic                       clear_dirty,
  input  logic                       write_tag,
  output logic                       hit,
  output logic                       snoop_hit,
  output dcache_pkg::dcache_frame_t  frame,
  output dcache_pkg::dcache_frame_t  snoop_frame
);

  import dcache_pkg::*;

  localparam int N_SETS = 2**`DCACHE_IDX_W;

  logic [N_SETS-1:0]         valid;
  logic [N_SETS-1:0]         dirty;
  logic [`DCACHE_TAG_W-1:0]  tags [N_SETS];
  word_t [`DCACHE_BLK_WORDS-1:0] data_mem [N_SETS];

  // flag bits are written at the demand index, which the controller
  // steers to the snoop index while it serves a snoop.
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      valid <= '0;
      dirty <= '0;
    end
    else
    begin
      if (set_valid)
        valid[idx] <= 1'b1;
      else if (clear_valid)
        valid[idx] <= 1'b0;

      if (set_dirty)
        dirty[idx] <= 1'b1;
      else if (clear_dirty)
        dirty[idx] <= 1'b0;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (write_tag)
      tags[idx] <= tag;
    if (wen)
      data_mem[idx][wword] <= wdat;
  end

  always_comb
  begin
    frame.valid = valid[idx];
    frame.dirty = dirty[idx];
    frame.tag   = tags[idx];
    frame.data  = data_mem[idx];
  end

  always_comb
  begin
    snoop_frame.valid = valid[snoop_idx];
    snoop_frame.dirty = dirty[snoop_idx];
    snoop_frame.tag   = tags[snoop_idx];
    snoop_frame.data  = data_mem[snoop_idx];
  end

  // the two ports compare independently so a snoop can be checked while
  // a demand request is held.
  assign hit       = frame.valid && (frame.tag == tag);
  assign snoop_hit = snoop_frame.valid && (snoop_frame.tag == snoop_tag);

  // the controller must never ask for a line to become valid and invalid at once.
  valid_set_clear_excl: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(set_valid && clear_valid)
  );

endmodule

// ==== design/dcache_pkg.sv ====
`include "dcache_settings.svh"

package dcache_pkg;

  // address layout: bits 1..0 byte offset, bit 2 block word, bits 5..3 set index,
  // and the remaining upper bits form the tag.

  typedef logic [`DCACHE_WORD_W-1:0] word_t;

  // valid and dirty together encode MSI: invalid, shared (clean) or modified (dirty).
  typedef struct packed {
    logic                     valid;
    logic                     dirty;
    logic [`DCACHE_TAG_W-1:0] tag;
    word_t [`DCACHE_BLK_WORDS-1:0] data;
  } dcache_frame_t;

  typedef enum logic [3:0] {
    IDLE,
    INV_REQ,
    EVICT_WB1,
    EVICT_WB2,
    FILL1,
    FILL2,
    FILL_DONE,
    SNOOP_WB1,
    SNOOP_WB2,
    SNOOP_TRANS
  } dcache_state_t;

endpackage

// ==== design/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// set index width, giving eight sets.
`define DCACHE_IDX_W 3

// data and address word width.
`define DCACHE_WORD_W 32

// words per block. The block word select is a single address bit.
`define DCACHE_BLK_WORDS 2

// tag is what is left after index, block word bit and byte offset.
`define DCACHE_TAG_W (`DCACHE_WORD_W - `DCACHE_IDX_W - 3)

`endif

// ==== verification/dcache_mem_model.sv ====
`timescale 1ns/1ps

module dcache_mem_model #(
  parameter int                MEM_WORDS = 256,
  parameter int                MAX_WAIT  = 3,
  parameter dcache_pkg::word_t PATTERN   = 32'h5a3c_96e1
) (
  input  logic               CLK,
  input  logic               dren,
  input  logic               dwen,
  input  dcache_pkg::word_t  daddr,
  input  dcache_pkg::word_t  dstore,
  output logic               dwait,
  output dcache_pkg::word_t  dload,
  input  logic               cc_inv_req,
  input  dcache_pkg::word_t  cc_addr,
  output logic               cc_grant,
  output int                 read_cnt,
  output int                 write_cnt,
  output int                 inv_cnt,
  output dcache_pkg::word_t  inv_addr
);

  import dcache_pkg::*;

  localparam int AW = $clog2(MEM_WORDS);

  word_t mem [MEM_WORDS];
  int    wait_cnt;
  int    grant_cnt;

  // every word starts as its own byte address mixed with the pattern.
  initial
  begin
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = word_t'(i * 4) ^ PATTERN;
    dwait     = 1'b1;
    dload     = '0;
    cc_grant  = 1'b0;
    read_cnt  = 0;
    write_cnt = 0;
    inv_cnt   = 0;
    inv_addr  = '0;
    wait_cnt  = 1;
    grant_cnt = 1;
  end

  always @(negedge CLK)
  begin
    if (dren || dwen)
    begin
      if (wait_cnt == 0)
      begin
        dwait = 1'b0;
        dload = mem[daddr[2 +: AW]];
      end
      else
      begin
        dwait    = 1'b1;
        wait_cnt = wait_cnt - 1;
      end
    end
    else
      dwait = 1'b1;

    // the grant is a single-cycle pulse after a random delay.
    if (cc_grant)
    begin
      cc_grant  = 1'b0;
      grant_cnt = $urandom_range(MAX_WAIT, 0);
    end
    else if (cc_inv_req)
    begin
      if (grant_cnt == 0)
        cc_grant = 1'b1;
      else
        grant_cnt = grant_cnt - 1;
    end
  end

  always @(posedge CLK)
  begin
    if ((dren || dwen) && !dwait)
    begin
      if (dwen)
      begin
        mem[daddr[2 +: AW]] = dstore;
        write_cnt           = write_cnt + 1;
      end
      else
        read_cnt = read_cnt + 1;
      wait_cnt = $urandom_range(MAX_WAIT, 0);
    end
    if (cc_inv_req && cc_grant)
    begin
      inv_cnt  = inv_cnt + 1;
      inv_addr = cc_addr;
    end
  end

endmodule

// ==== verification/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;

  import dcache_pkg::*;

  localparam int    MEM_WORDS = 256;
  localparam int    MAX_WAIT  = 3;
  localparam int    SEED      = 28;
  localparam word_t PATTERN   = 32'h5a3c_96e1;

  // worst transaction: two write-backs, two fills, a grant, the hit cycle and idle cycles.
  localparam int XACT_CYCLES = 5 * (MAX_WAIT + 1) + 6;
  localparam int N_XACTS     = 14;
  localparam int WAIT_LIMIT  = 4 * XACT_CYCLES;
  localparam int WATCHDOG_NS = (N_XACTS * XACT_CYCLES + 4) * 10 * 4;

  // blocks A, B and C share set 1; D and E sit in sets 2 and 3.
  localparam word_t BLK_A = 32'h0000_0008;
  localparam word_t BLK_B = 32'h0000_0048;
  localparam word_t BLK_C = 32'h0000_0088;
  localparam word_t BLK_D = 32'h0000_0010;
  localparam word_t BLK_E = 32'h0000_0018;
  localparam word_t VAL_V = 32'hcafe_0001;
  localparam word_t VAL_W = 32'hcafe_0002;
  localparam word_t VAL_X = 32'hbeef_0003;
  localparam word_t VAL_Y = 32'hbeef_0004;
  localparam word_t VAL_Z = 32'hbeef_0005;

  logic  CLK = 1'b0;
  logic  nRST;
  logic  dmem_ren, dmem_wen;
  word_t dmem_addr, dmem_store, dmem_load;
  logic  dhit;
  logic  dwait;
  word_t dload;
  logic  dren, dwen;
  word_t daddr, dstore;
  logic  cc_grant, cc_inv_req;
  word_t cc_addr;
  logic  snoop_req, snoop_excl, snoop_ack;
  word_t snoop_addr;
  int    rd_cnt, wr_cnt, inv_cnt;
  word_t inv_addr;

  always #5 CLK = ~CLK;

  dcache u_dut (.*);

  dcache_mem_model #(
    .MEM_WORDS (MEM_WORDS),
    .MAX_WAIT  (MAX_WAIT),
    .PATTERN   (PATTERN)
  ) u_mem (
    .CLK        (CLK),
    .dren       (dren),
    .dwen       (dwen),
    .daddr      (daddr),
    .dstore     (dstore),
    .dwait      (dwait),
    .dload      (dload),
    .cc_inv_req (cc_inv_req),
    .cc_addr    (cc_addr),
    .cc_grant   (cc_grant),
    .read_cnt   (rd_cnt),
    .write_cnt  (wr_cnt),
    .inv_cnt    (inv_cnt),
    .inv_addr   (inv_addr)
  );

  task automatic stop_with_failure();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input word_t got, input word_t exp);
    assert (got === exp)
    else
    begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic word_t preload_word(input word_t addr);
    return addr ^ PATTERN;
  endfunction

  function automatic word_t mem_word(input word_t addr);
    return u_mem.mem[addr[9:2]];
  endfunction

  task automatic cache_access(input logic wr, input word_t addr, input word_t wdata,
                              output word_t rdata);
    int cycles;
    cycles = 0;
    @(negedge CLK);
    dmem_ren   = !wr;
    dmem_wen   = wr;
    dmem_addr  = addr;
    dmem_store = wdata;
    #1;
    while (!dhit)
    begin
      if (cycles == WAIT_LIMIT)
      begin
        $display("no dhit for the access to address %h", addr);
        stop_with_failure();
      end
      @(negedge CLK);
      #1;
      cycles++;
    end
    rdata = dmem_load;
    @(negedge CLK);
    dmem_ren = 1'b0;
    dmem_wen = 1'b0;
  endtask

  task automatic snoop_line(input word_t addr, input logic excl);
    int cycles;
    cycles = 0;
    @(negedge CLK);
    snoop_req  = 1'b1;
    snoop_excl = excl;
    snoop_addr = addr;
    #1;
    while (!snoop_ack)
    begin
      if (cycles == WAIT_LIMIT)
      begin
        $display("no snoop_ack for the snoop of address %h", addr);
        stop_with_failure();
      end
      @(negedge CLK);
      #1;
      cycles++;
    end
    @(negedge CLK);
    snoop_req  = 1'b0;
    snoop_excl = 1'b0;
  endtask

  task automatic reset_outputs_low();
    #1;
    check_eq("dhit", dhit, 0);
    check_eq("dren", dren, 0);
    check_eq("dwen", dwen, 0);
    check_eq("cc_inv_req", cc_inv_req, 0);
    check_eq("snoop_ack", snoop_ack, 0);
  endtask

  task automatic read_miss_then_hit();
    word_t data;
    int    reads;
    reads = rd_cnt;
    cache_access(1'b0, BLK_A, '0, data);
    check_eq("dmem_load", data, preload_word(BLK_A));
    check_eq("memory reads", rd_cnt - reads, 2);
    check_eq("memory writes", wr_cnt, 0);
    reads = rd_cnt;
    cache_access(1'b0, BLK_A + 4, '0, data);
    check_eq("dmem_load", data, preload_word(BLK_A + 4));
    check_eq("memory reads", rd_cnt - reads, 0);
  endtask

  task automatic shared_write_readback();
    word_t data;
    int    invs;
    int    writes;
    invs   = inv_cnt;
    writes = wr_cnt;
    cache_access(1'b1, BLK_A, VAL_V, data);
    check_eq("invalidates", inv_cnt - invs, 1);
    check_eq("cc_addr", inv_addr, BLK_A);
    cache_access(1'b0, BLK_A, '0, data);
    check_eq("dmem_load", data, VAL_V);
    check_eq("memory writes", wr_cnt - writes, 0);
    check_eq("memory word", mem_word(BLK_A), preload_word(BLK_A));
  endtask

  task automatic dirty_eviction();
    word_t data;
    int    invs;
    int    writes;
    invs = inv_cnt;
    cache_access(1'b1, BLK_A + 4, VAL_W, data);
    check_eq("invalidates", inv_cnt - invs, 0);
    writes = wr_cnt;
    cache_access(1'b0, BLK_B, '0, data);
    check_eq("dmem_load", data, preload_word(BLK_B));
    check_eq("memory writes", wr_cnt - writes, 0);
    // block A is now least recently used and dirty.
    cache_access(1'b0, BLK_C, '0, data);
    check_eq("dmem_load", data, preload_word(BLK_C));
    check_eq("memory writes", wr_cnt - writes, 2);
    check_eq("memory word", mem_word(BLK_A), VAL_V);
    check_eq("memory word", mem_word(BLK_A + 4), VAL_W);
  endtask

  task automatic exclusive_snoop();
    word_t data;
    int    invs;
    int    reads;
    int    writes;
    invs  = inv_cnt;
    reads = rd_cnt;
    cache_access(1'b1, BLK_D, VAL_X, data);
    check_eq("invalidates", inv_cnt - invs, 1);
    check_eq("memory reads", rd_cnt - reads, 2);
    writes = wr_cnt;
    snoop_line(BLK_D, 1'b1);
    check_eq("memory writes", wr_cnt - writes, 2);
    check_eq("memory word", mem_word(BLK_D), VAL_X);
    check_eq("memory word", mem_word(BLK_D + 4), preload_word(BLK_D + 4));
    reads = rd_cnt;
    cache_access(1'b0, BLK_D, '0, data);
    check_eq("dmem_load", data, VAL_X);
    check_eq("memory reads", rd_cnt - reads, 2);
  endtask

  task automatic plain_snoop();
    word_t data;
    int    invs;
    int    reads;
    int    writes;
    cache_access(1'b1, BLK_E + 4, VAL_Y, data);
    writes = wr_cnt;
    snoop_line(BLK_E, 1'b0);
    check_eq("memory writes", wr_cnt - writes, 2);
    check_eq("memory word", mem_word(BLK_E), preload_word(BLK_E));
    check_eq("memory word", mem_word(BLK_E + 4), VAL_Y);
    reads = rd_cnt;
    cache_access(1'b0, BLK_E + 4, '0, data);
    check_eq("dmem_load", data, VAL_Y);
    check_eq("memory reads", rd_cnt - reads, 0);
    // the line is shared again, so a write must ask the bus first.
    invs = inv_cnt;
    cache_access(1'b1, BLK_E, VAL_Z, data);
    check_eq("invalidates", inv_cnt - invs, 1);
    check_eq("cc_addr", inv_addr, BLK_E);
    check_eq("memory reads", rd_cnt - reads, 0);
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    stop_with_failure();
  end

  initial
  begin
    void'($urandom(SEED));
    nRST       = 1'b0;
    dmem_ren   = 1'b0;
    dmem_wen   = 1'b0;
    dmem_addr  = '0;
    dmem_store = '0;
    snoop_req  = 1'b0;
    snoop_excl = 1'b0;
    snoop_addr = '0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    reset_outputs_low();
    read_miss_then_hit();
    shared_write_readback();
    dirty_eviction();
    exclusive_snoop();
    plain_snoop();
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+design
design/dcache_pkg.sv
design/dcache_frame_array.sv
design/dcache_ctrl.sv
design/dcache.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv
